/* logic/core_ctrl_pkg.sv */
/*
  core control package
  address map, sizes and the enums shared by the system-clock control block
*/
package core_ctrl_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  localparam int INTERACT_DEPTH = 64;
  localparam int INTERACT_IDX_W = $clog2(INTERACT_DEPTH);
  localparam int SLOT_COUNT = 64;
  localparam int SLOT_IDX_W = $clog2(SLOT_COUNT);
  localparam int SLOT_ID_W = 16;

  // hold counter is wide enough for RESET_HOLD_CYCLES
  localparam int HOLD_CNT_W = 7;
  localparam logic [HOLD_CNT_W-1:0] RESET_HOLD_CYCLES = 7'd64;
  localparam int TICKS_PER_SECOND = 57_120_000;

  ////////////////////////////////////////////////////////////
  // address map

  localparam logic [ADDR_W-1:0] CTRL_BASE = 32'h1000_0000;
  localparam logic [3:0] REG_MENU_RESET = 4'h0;
  localparam logic [3:0] REG_RESET_PLUS = 4'h4;
  localparam logic [3:0] REG_RTC_SECONDS = 4'h8;
  // one word per 4 bytes, up to 0x1000_01fc
  localparam logic [ADDR_W-1:0] INTERACT_BASE = 32'h1000_0100;
  localparam logic [ADDR_W-1:0] SLOT_BASE = 32'h2000_0000;

  typedef enum logic [1:0] {
    REGION_CTRL,
    REGION_INTERACT,
    REGION_SLOT,
    REGION_NONE
  } bus_region_e;

  typedef enum logic {
    OWNER_BRIDGE,
    OWNER_SLOT_WRITER
  } bus_owner_e;

  typedef enum logic {
    IDLE,
    CYCLE
  } bridge_state_e;

endpackage

/* logic/wb_if.sv */
/*
  wishbone classic link
  single master to single slave, full-word accesses only
*/
`timescale 1ns/1ps

interface wb_if;
  logic                             cyc;
  logic                             stb;
  logic                             we;
  logic [core_ctrl_pkg::ADDR_W-1:0] adr;
  logic [core_ctrl_pkg::DATA_W-1:0] dat_w;
  logic [core_ctrl_pkg::DATA_W-1:0] dat_r;
  logic                             ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );
endinterface

/* logic/wb_shared_bus.sv */
/*
  shared wishbone bus
  two masters, alternating priority on a tie, decode to three slaves
  unmapped addresses get a zero reply from a built-in responder
*/
`timescale 1ns/1ps

module wb_shared_bus (
  input  logic clk_sys_57_12,
  input  logic rst,
  wb_if.slave  bridge_bus,
  wb_if.slave  writer_bus,
  wb_if.master ctrl_bus,
  wb_if.master interact_bus,
  wb_if.master slot_bus
);

  core_ctrl_pkg::bus_owner_e        owner_q;
  core_ctrl_pkg::bus_owner_e        owner;
  core_ctrl_pkg::bus_region_e       region;
  logic                             active_q;
  logic                             owner_q_cyc;
  logic                             m_cyc;
  logic                             m_stb;
  logic                             m_we;
  logic [core_ctrl_pkg::ADDR_W-1:0] m_adr;
  logic [core_ctrl_pkg::DATA_W-1:0] m_dat_w;
  logic                             s_ack;
  logic [core_ctrl_pkg::DATA_W-1:0] s_dat_r;
  logic                             none_ack_q;

  function automatic core_ctrl_pkg::bus_region_e decode(
    input logic [core_ctrl_pkg::ADDR_W-1:0] adr
  );
    if (adr[31:4] == core_ctrl_pkg::CTRL_BASE[31:4]) return core_ctrl_pkg::REGION_CTRL;
    if (adr[31:8] == core_ctrl_pkg::INTERACT_BASE[31:8]) return core_ctrl_pkg::REGION_INTERACT;
    if (adr[31:8] == core_ctrl_pkg::SLOT_BASE[31:8]) return core_ctrl_pkg::REGION_SLOT;
    return core_ctrl_pkg::REGION_NONE;
  endfunction

  ////////////////////////////////////////////////////////////
  // arbitration

  assign owner_q_cyc = (owner_q == core_ctrl_pkg::OWNER_BRIDGE) ? bridge_bus.cyc : writer_bus.cyc;

  always_comb begin
    if (active_q && owner_q_cyc) begin
      owner = owner_q;
    end else if (bridge_bus.cyc && writer_bus.cyc) begin
      // tie goes to whoever did not own the last cycle
      owner = (owner_q == core_ctrl_pkg::OWNER_BRIDGE) ? core_ctrl_pkg::OWNER_SLOT_WRITER
                                                       : core_ctrl_pkg::OWNER_BRIDGE;
    end else if (writer_bus.cyc) begin
      owner = core_ctrl_pkg::OWNER_SLOT_WRITER;
    end else begin
      owner = core_ctrl_pkg::OWNER_BRIDGE;
    end
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      owner_q  <= core_ctrl_pkg::OWNER_SLOT_WRITER;
      active_q <= 1'b0;
    end else begin
      active_q <= m_cyc;
      if (m_cyc) begin
        owner_q <= owner;
      end
    end
  end

  // selected master
  always_comb begin
    if (owner == core_ctrl_pkg::OWNER_BRIDGE) begin
      m_cyc   = bridge_bus.cyc;
      m_stb   = bridge_bus.stb;
      m_we    = bridge_bus.we;
      m_adr   = bridge_bus.adr;
      m_dat_w = bridge_bus.dat_w;
    end else begin
      m_cyc   = writer_bus.cyc;
      m_stb   = writer_bus.stb;
      m_we    = writer_bus.we;
      m_adr   = writer_bus.adr;
      m_dat_w = writer_bus.dat_w;
    end
  end

  ////////////////////////////////////////////////////////////
  // decode and routing

  assign region = decode(m_adr);

  assign ctrl_bus.cyc     = m_cyc && region == core_ctrl_pkg::REGION_CTRL;
  assign ctrl_bus.stb     = m_stb && ctrl_bus.cyc;
  assign ctrl_bus.we      = m_we;
  assign ctrl_bus.adr     = m_adr;
  assign ctrl_bus.dat_w   = m_dat_w;
  assign interact_bus.cyc   = m_cyc && region == core_ctrl_pkg::REGION_INTERACT;
  assign interact_bus.stb   = m_stb && interact_bus.cyc;
  assign interact_bus.we    = m_we;
  assign interact_bus.adr   = m_adr;
  assign interact_bus.dat_w = m_dat_w;
  assign slot_bus.cyc     = m_cyc && region == core_ctrl_pkg::REGION_SLOT;
  assign slot_bus.stb     = m_stb && slot_bus.cyc;
  assign slot_bus.we      = m_we;
  assign slot_bus.adr     = m_adr;
  assign slot_bus.dat_w   = m_dat_w;

  // default responder, writes dropped
  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= m_cyc && m_stb && region == core_ctrl_pkg::REGION_NONE && !none_ack_q;
    end
  end

  always_comb begin
    case (region)
      core_ctrl_pkg::REGION_CTRL: begin
        s_ack   = ctrl_bus.ack;
        s_dat_r = ctrl_bus.dat_r;
      end
      core_ctrl_pkg::REGION_INTERACT: begin
        s_ack   = interact_bus.ack;
        s_dat_r = interact_bus.dat_r;
      end
      core_ctrl_pkg::REGION_SLOT: begin
        s_ack   = slot_bus.ack;
        s_dat_r = slot_bus.dat_r;
      end
      default: begin
        s_ack   = none_ack_q;
        s_dat_r = '0;
      end
    endcase
  end

  assign bridge_bus.ack   = s_ack && owner == core_ctrl_pkg::OWNER_BRIDGE;
  assign bridge_bus.dat_r = s_dat_r;
  assign writer_bus.ack   = s_ack && owner == core_ctrl_pkg::OWNER_SLOT_WRITER;
  assign writer_bus.dat_r = s_dat_r;

endmodule

/* logic/bridge_wb_master.sv */
/*
  host bridge master
  turns single-cycle read and write pulses into wishbone cycles
*/
`timescale 1ns/1ps

module bridge_wb_master (
  input  logic                             clk_sys_57_12,
  input  logic                             rst,
  input  logic [core_ctrl_pkg::ADDR_W-1:0] bridge_addr,
  input  logic                             bridge_rd,
  input  logic                             bridge_wr,
  input  logic [core_ctrl_pkg::DATA_W-1:0] bridge_wr_data,
  output logic [core_ctrl_pkg::DATA_W-1:0] bridge_rd_data,
  output logic                             bridge_rd_valid,
  output logic                             bridge_busy,
  wb_if.master                             bus
);

  core_ctrl_pkg::bridge_state_e     state_q;
  logic                             we_q;
  logic [core_ctrl_pkg::ADDR_W-1:0] adr_q;
  logic [core_ctrl_pkg::DATA_W-1:0] dat_q;

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      state_q         <= core_ctrl_pkg::IDLE;
      bridge_rd_valid <= 1'b0;
    end else begin
      bridge_rd_valid <= 1'b0;
      case (state_q)
        core_ctrl_pkg::IDLE: begin
          if (bridge_rd || bridge_wr) begin
            state_q <= core_ctrl_pkg::CYCLE;
          end
        end
        default: begin
          if (bus.ack) begin
            state_q         <= core_ctrl_pkg::IDLE;
            bridge_rd_valid <= !we_q;
          end
        end
      endcase
    end
  end

  // request payload, write wins if both pulse together
  always_ff @(posedge clk_sys_57_12) begin
    if (state_q == core_ctrl_pkg::IDLE && (bridge_rd || bridge_wr)) begin
      we_q  <= bridge_wr;
      adr_q <= bridge_addr;
      dat_q <= bridge_wr_data;
    end
    if (state_q == core_ctrl_pkg::CYCLE && bus.ack && !we_q) begin
      bridge_rd_data <= bus.dat_r;
    end
  end

  assign bridge_busy = state_q == core_ctrl_pkg::CYCLE;
  assign bus.cyc     = bridge_busy;
  assign bus.stb     = bridge_busy;
  assign bus.we      = we_q;
  assign bus.adr     = adr_q;
  assign bus.dat_w   = dat_q;

endmodule

/* logic/slot_size_writer.sv */
/*
  slot size writer
  holds one slot size update and writes it to the slot table
*/
`timescale 1ns/1ps

module slot_size_writer (
  input  logic                                clk_sys_57_12,
  input  logic                                rst,
  input  logic                                slot_update,
  input  logic [core_ctrl_pkg::SLOT_ID_W-1:0] slot_update_id,
  input  logic [core_ctrl_pkg::DATA_W-1:0]    slot_update_size,
  output logic                                slot_update_ready,
  wb_if.master                                bus
);

  localparam int PAD_W = core_ctrl_pkg::ADDR_W - core_ctrl_pkg::SLOT_IDX_W - 2;

  logic                             pending_q;
  logic [core_ctrl_pkg::ADDR_W-1:0] adr_q;
  logic [core_ctrl_pkg::DATA_W-1:0] size_q;

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      pending_q <= !bus.ack;
    end else begin
      pending_q <= slot_update;
    end
  end

  // entry address is the base plus one word per slot index
  always_ff @(posedge clk_sys_57_12) begin
    if (!pending_q && slot_update) begin
      adr_q  <= core_ctrl_pkg::SLOT_BASE +
                {{PAD_W{1'b0}}, slot_update_id[core_ctrl_pkg::SLOT_IDX_W-1:0], 2'b00};
      size_q <= slot_update_size;
    end
  end

  assign slot_update_ready = !pending_q;
  assign bus.cyc   = pending_q;
  assign bus.stb   = pending_q;
  assign bus.we    = 1'b1;
  assign bus.adr   = adr_q;
  assign bus.dat_w = size_q;

endmodule

/* logic/ctrl_regs.sv */
/*
  control registers
  menu reset, reset-button enable, rtc seconds
  also owns the core reset hold timer
*/
`timescale 1ns/1ps

module ctrl_regs #(
  parameter int ticks_per_second = core_ctrl_pkg::TICKS_PER_SECOND
) (
  input  logic                             clk_sys_57_12,
  input  logic                             rst,
  wb_if.slave                              bus,
  input  logic                             reset_button,
  output logic                             core_reset,
  output logic [core_ctrl_pkg::DATA_W-1:0] rtc_seconds
);

  logic                                 sel;
  logic                                 wr_en;
  logic [3:0]                           offset;
  logic                                 ack_q;
  logic                                 enable_q;
  logic                                 button_q;
  logic                                 start_hold;
  logic [core_ctrl_pkg::HOLD_CNT_W-1:0] hold_q;
  logic [31:0]                          div_q;

  assign sel    = bus.cyc && bus.stb;
  assign offset = bus.adr[3:0];
  // writes land in the ack cycle
  assign wr_en  = sel && bus.we && ack_q;

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sel && !ack_q;
    end
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (sel && !ack_q) begin
      case (offset)
        core_ctrl_pkg::REG_RESET_PLUS:  bus.dat_r <= {31'd0, enable_q};
        core_ctrl_pkg::REG_RTC_SECONDS: bus.dat_r <= rtc_seconds;
        default:                        bus.dat_r <= '0;
      endcase
    end
  end

  assign bus.ack = ack_q;

  ////////////////////////////////////////////////////////////
  // reset hold timer

  assign start_hold = (wr_en && offset == core_ctrl_pkg::REG_MENU_RESET) ||
                      (reset_button && !button_q && enable_q);

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      enable_q <= 1'b0;
      button_q <= 1'b0;
      hold_q   <= '0;
    end else begin
      button_q <= reset_button;
      if (wr_en && offset == core_ctrl_pkg::REG_RESET_PLUS) begin
        enable_q <= bus.dat_w[0];
      end
      if (start_hold) begin
        hold_q <= core_ctrl_pkg::RESET_HOLD_CYCLES;
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end
    end
  end

  assign core_reset = rst || hold_q != '0;

  ////////////////////////////////////////////////////////////
  // rtc seconds

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      rtc_seconds <= '0;
      div_q       <= '0;
    end else if (wr_en && offset == core_ctrl_pkg::REG_RTC_SECONDS) begin
      rtc_seconds <= bus.dat_w;
      div_q       <= '0;
    end else if (div_q == ticks_per_second - 1) begin
      rtc_seconds <= rtc_seconds + 32'd1;
      div_q       <= '0;
    end else begin
      div_q <= div_q + 32'd1;
    end
  end

endmodule

/* logic/interact_regs.sv */
/*
  interact register file
  64 words, read and written over wishbone
*/
`timescale 1ns/1ps

module interact_regs (
  input  logic clk_sys_57_12,
  input  logic rst,
  wb_if.slave  bus
);

  logic [core_ctrl_pkg::DATA_W-1:0]         mem [core_ctrl_pkg::INTERACT_DEPTH];
  logic [core_ctrl_pkg::INTERACT_IDX_W-1:0] idx;
  logic                                     sel;
  logic                                     ack_q;

  assign sel = bus.cyc && bus.stb && !ack_q;
  // word index from address bits 7:2
  assign idx = bus.adr[core_ctrl_pkg::INTERACT_IDX_W+1:2];

  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sel;
    end
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (sel && bus.we) begin
      mem[idx] <= bus.dat_w;
    end
    if (sel) begin
      bus.dat_r <= mem[idx];
    end
  end

  assign bus.ack = ack_q;

endmodule

/* logic/slot_table.sv */
/*
  data-slot size table
  bus port for the writer and host, registered lookup for the active slot
*/
`timescale 1ns/1ps

module slot_table (
  input  logic                                clk_sys_57_12,
  input  logic                                rst,
  wb_if.slave                                 bus,
  input  logic [core_ctrl_pkg::SLOT_ID_W-1:0] active_slot_id,
  output logic [core_ctrl_pkg::DATA_W-1:0]    active_slot_size
);

  logic [core_ctrl_pkg::DATA_W-1:0]     sizes [core_ctrl_pkg::SLOT_COUNT];
  logic [core_ctrl_pkg::SLOT_IDX_W-1:0] idx;
  logic                                 sel;
  logic                                 ack_q;

  assign sel = bus.cyc && bus.stb && !ack_q;
  assign idx = bus.adr[core_ctrl_pkg::SLOT_IDX_W+1:2];

  // every slot reads as empty after reset
  always_ff @(posedge clk_sys_57_12) begin
    if (rst) begin
      for (int i = 0; i < core_ctrl_pkg::SLOT_COUNT; i++) begin
        sizes[i] <= '0;
      end
      ack_q <= 1'b0;
    end else begin
      ack_q <= sel;
      if (sel && bus.we) begin
        sizes[idx] <= bus.dat_w;
      end
    end
  end

  always_ff @(posedge clk_sys_57_12) begin
    if (sel) begin
      bus.dat_r <= sizes[idx];
    end
    // slot index is the low bits of the id
    active_slot_size <= sizes[active_slot_id[core_ctrl_pkg::SLOT_IDX_W-1:0]];
  end

  assign bus.ack = ack_q;

endmodule

/* logic/core_ctrl_top.sv */
/*
  system-clock control block
  host bridge and slot writer share one wishbone bus to the
  control registers, interact registers and slot size table
*/
`timescale 1ns/1ps

module core_ctrl_top #(
  parameter int ticks_per_second = core_ctrl_pkg::TICKS_PER_SECOND
) (
  input  logic                                clk_sys_57_12,
  input  logic                                rst,
  // host bridge
  input  logic [core_ctrl_pkg::ADDR_W-1:0]    bridge_addr,
  input  logic                                bridge_rd,
  input  logic                                bridge_wr,
  input  logic [core_ctrl_pkg::DATA_W-1:0]    bridge_wr_data,
  output logic [core_ctrl_pkg::DATA_W-1:0]    bridge_rd_data,
  output logic                                bridge_rd_valid,
  output logic                                bridge_busy,
  // slot size updates
  input  logic                                slot_update,
  input  logic [core_ctrl_pkg::SLOT_ID_W-1:0] slot_update_id,
  input  logic [core_ctrl_pkg::DATA_W-1:0]    slot_update_size,
  output logic                                slot_update_ready,
  // control and status
  input  logic                                reset_button,
  output logic                                core_reset,
  output logic [core_ctrl_pkg::DATA_W-1:0]    rtc_seconds,
  input  logic [core_ctrl_pkg::SLOT_ID_W-1:0] active_slot_id,
  output logic [core_ctrl_pkg::DATA_W-1:0]    active_slot_size
);

  wb_if bridge_bus ();
  wb_if slot_writer_bus ();
  wb_if ctrl_bus ();
  wb_if interact_bus ();
  wb_if slot_bus ();

  ////////////////////////////////////////////////////////////
  // bus masters

  bridge_wb_master bridge_wb_master_inst (
    .clk_sys_57_12   (clk_sys_57_12),
    .rst             (rst),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .bridge_rd_valid (bridge_rd_valid),
    .bridge_busy     (bridge_busy),
    .bus             (bridge_bus)
  );

  slot_size_writer slot_size_writer_inst (
    .clk_sys_57_12     (clk_sys_57_12),
    .rst               (rst),
    .slot_update       (slot_update),
    .slot_update_id    (slot_update_id),
    .slot_update_size  (slot_update_size),
    .slot_update_ready (slot_update_ready),
    .bus               (slot_writer_bus)
  );

  wb_shared_bus wb_shared_bus_inst (
    .clk_sys_57_12 (clk_sys_57_12),
    .rst           (rst),
    .bridge_bus    (bridge_bus),
    .writer_bus    (slot_writer_bus),
    .ctrl_bus      (ctrl_bus),
    .interact_bus  (interact_bus),
    .slot_bus      (slot_bus)
  );

  ////////////////////////////////////////////////////////////
  // bus slaves

  ctrl_regs #(
    .ticks_per_second (ticks_per_second)
  ) ctrl_regs_inst (
    .clk_sys_57_12 (clk_sys_57_12),
    .rst           (rst),
    .bus           (ctrl_bus),
    .reset_button  (reset_button),
    .core_reset    (core_reset),
    .rtc_seconds   (rtc_seconds)
  );

  interact_regs interact_regs_inst (
    .clk_sys_57_12 (clk_sys_57_12),
    .rst           (rst),
    .bus           (interact_bus)
  );

  slot_table slot_table_inst (
    .clk_sys_57_12    (clk_sys_57_12),
    .rst              (rst),
    .bus              (slot_bus),
    .active_slot_id   (active_slot_id),
    .active_slot_size (active_slot_size)
  );

endmodule

/* test/tb_host_tasks.svh */
/*
  host-side tasks for the control block testbench
  bridge reads and writes, slot updates, reset pulse timing, value compare
*/
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// inputs change and outputs are sampled 1 ns after the rising edge
task automatic next_cycle();
  @(posedge clk_sys_57_12);
  #1;
endtask

task automatic abort_run(input string reason);
  $display("error: %s", reason);
  $display("SOME TESTS FAILED");
  $fatal(1, "simulation stopped on error");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    $display("SOME TESTS FAILED");
    $fatal(1, "value mismatch");
  end
endtask

task automatic wait_bridge_idle(input string reason);
  int n;
  n = 0;
  while (bridge_busy) begin
    next_cycle();
    n++;
    if (n >= WAIT_LIMIT) begin
      abort_run(reason);
    end
  end
endtask

task automatic wait_slot_ready(input string reason);
  int n;
  n = 0;
  while (!slot_update_ready) begin
    next_cycle();
    n++;
    if (n >= WAIT_LIMIT) begin
      abort_run(reason);
    end
  end
endtask

task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
  wait_bridge_idle("bridge stayed busy before a write");
  model_write(addr, data);
  bridge_addr    = addr;
  bridge_wr_data = data;
  bridge_wr      = 1'b1;
  next_cycle();
  bridge_wr = 1'b0;
  check_value("bridge_busy", bridge_busy, 1);
  wait_bridge_idle("bridge write was never acknowledged");
endtask

// expected data goes to the checker queue at issue time
task automatic read_word(input logic [31:0] addr);
  int n;
  wait_bridge_idle("bridge stayed busy before a read");
  expected_q.push_back(expected_read(addr));
  bridge_addr = addr;
  bridge_rd   = 1'b1;
  next_cycle();
  bridge_rd = 1'b0;
  n = 0;
  while (!bridge_rd_valid) begin
    next_cycle();
    n++;
    if (n >= WAIT_LIMIT) begin
      abort_run("bridge read returned no data");
    end
  end
endtask

task automatic send_slot_update(input logic [15:0] id, input logic [31:0] size);
  wait_slot_ready("slot writer never became ready");
  slot_model[id[5:0]] = size;
  slot_update_id   = id;
  slot_update_size = size;
  slot_update      = 1'b1;
  next_cycle();
  slot_update = 1'b0;
  check_value("slot_update_ready", slot_update_ready, 0);
  wait_slot_ready("slot size write was never acknowledged");
endtask

task automatic measure_reset_pulse(output int len);
  int n;
  n = 0;
  while (!core_reset) begin
    next_cycle();
    n++;
    if (n >= WAIT_LIMIT) begin
      abort_run("core reset never went high");
    end
  end
  len = 0;
  while (core_reset) begin
    next_cycle();
    len++;
    if (len >= WAIT_LIMIT) begin
      abort_run("core reset never went low again");
    end
  end
endtask

`endif

/* test/tb_core_ctrl.sv */
/*
  testbench for the system-clock control block
  register model, read checker and the directed and random sequences
*/
`timescale 1ns/1ps

module tb_core_ctrl;

  localparam int WAIT_LIMIT = 1000;
  localparam int CLK_PERIOD = 10;
  localparam int RTC_TICKS = 20;
  localparam logic [31:0] UNMAPPED_ADDR [4] = '{
    32'h3000_0000, 32'h1000_0010, 32'h1000_0200, 32'h2000_0100
  };

  logic        clk_sys_57_12;
  logic        rst;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  logic        bridge_rd_valid;
  logic        bridge_busy;
  logic        slot_update;
  logic [15:0] slot_update_id;
  logic [31:0] slot_update_size;
  logic        slot_update_ready;
  logic        reset_button;
  logic        core_reset;
  logic [31:0] rtc_seconds;
  logic [15:0] active_slot_id;
  logic [31:0] active_slot_size;

  // register model
  logic [31:0] interact_model [64];
  logic        interact_written [64];
  logic [31:0] slot_model [64];
  logic        enable_model;
  logic [31:0] seconds_model;
  logic [31:0] expected_q [$];

  core_ctrl_top #(
    .ticks_per_second (RTC_TICKS)
  ) core_ctrl_top_inst (
    .clk_sys_57_12     (clk_sys_57_12),
    .rst               (rst),
    .bridge_addr       (bridge_addr),
    .bridge_rd         (bridge_rd),
    .bridge_wr         (bridge_wr),
    .bridge_wr_data    (bridge_wr_data),
    .bridge_rd_data    (bridge_rd_data),
    .bridge_rd_valid   (bridge_rd_valid),
    .bridge_busy       (bridge_busy),
    .slot_update       (slot_update),
    .slot_update_id    (slot_update_id),
    .slot_update_size  (slot_update_size),
    .slot_update_ready (slot_update_ready),
    .reset_button      (reset_button),
    .core_reset        (core_reset),
    .rtc_seconds       (rtc_seconds),
    .active_slot_id    (active_slot_id),
    .active_slot_size  (active_slot_size)
  );

  initial begin
    clk_sys_57_12 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys_57_12 = ~clk_sys_57_12;
  end

  ////////////////////////////////////////////////////////////
  // reference model

  // regions by address range
  function automatic core_ctrl_pkg::bus_region_e region_of(input logic [31:0] addr);
    if (addr >= core_ctrl_pkg::CTRL_BASE && addr < core_ctrl_pkg::CTRL_BASE + 32'd16) begin
      return core_ctrl_pkg::REGION_CTRL;
    end
    if (addr >= core_ctrl_pkg::INTERACT_BASE && addr < core_ctrl_pkg::INTERACT_BASE + 32'd256) begin
      return core_ctrl_pkg::REGION_INTERACT;
    end
    if (addr >= core_ctrl_pkg::SLOT_BASE && addr < core_ctrl_pkg::SLOT_BASE + 32'd256) begin
      return core_ctrl_pkg::REGION_SLOT;
    end
    return core_ctrl_pkg::REGION_NONE;
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    case (region_of(addr))
      core_ctrl_pkg::REGION_CTRL: begin
        if (addr[3:0] == core_ctrl_pkg::REG_RESET_PLUS) begin
          return {31'd0, enable_model};
        end
        if (addr[3:0] == core_ctrl_pkg::REG_RTC_SECONDS) begin
          return seconds_model;
        end
        return 32'd0;
      end
      core_ctrl_pkg::REGION_INTERACT: return interact_model[addr[7:2]];
      core_ctrl_pkg::REGION_SLOT:     return slot_model[addr[7:2]];
      default:                        return 32'd0;
    endcase
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    case (region_of(addr))
      core_ctrl_pkg::REGION_CTRL: begin
        if (addr[3:0] == core_ctrl_pkg::REG_RESET_PLUS) begin
          enable_model = data[0];
        end
        if (addr[3:0] == core_ctrl_pkg::REG_RTC_SECONDS) begin
          seconds_model = data;
        end
      end
      core_ctrl_pkg::REGION_INTERACT: begin
        interact_model[addr[7:2]]   = data;
        interact_written[addr[7:2]] = 1'b1;
      end
      core_ctrl_pkg::REGION_SLOT: begin
        slot_model[addr[7:2]] = data;
      end
      default: ;
    endcase
  endfunction

  `include "tb_host_tasks.svh"

  // read checker samples mid-cycle
  always @(negedge clk_sys_57_12) begin
    if (!rst && bridge_rd_valid) begin
      if (expected_q.size() == 0) begin
        abort_run("read data arrived with no read outstanding");
      end else begin
        check_value("bridge_rd_data", bridge_rd_data, expected_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    int          len;
    int          idx;
    int          elapsed;
    time         t_load;
    logic [15:0] id;
    logic [31:0] lval;
    logic [31:0] c_addr;

    void'($urandom(32'hdc7a_594e));
    rst              = 1'b1;
    bridge_addr      = '0;
    bridge_rd        = 1'b0;
    bridge_wr        = 1'b0;
    bridge_wr_data   = '0;
    slot_update      = 1'b0;
    slot_update_id   = '0;
    slot_update_size = '0;
    reset_button     = 1'b0;
    active_slot_id   = '0;
    for (int i = 0; i < 64; i++) begin
      interact_model[i]   = '0;
      interact_written[i] = 1'b0;
      slot_model[i]       = '0;
    end
    enable_model  = 1'b0;
    seconds_model = '0;
    repeat (5) @(posedge clk_sys_57_12);
    #1;
    rst = 1'b0;
    next_cycle();
    check_value("bridge_busy", bridge_busy, 0);
    check_value("bridge_rd_valid", bridge_rd_valid, 0);
    check_value("core_reset", core_reset, 0);
    check_value("slot_update_ready", slot_update_ready, 1);
    check_value("rtc_seconds", rtc_seconds, 0);

    // interact words then unmapped space
    for (int i = 0; i < 24; i++) begin
      idx = $urandom_range(63, 0);
      write_word(core_ctrl_pkg::INTERACT_BASE + 32'(idx * 4), $urandom());
    end
    for (int i = 0; i < 64; i++) begin
      if (interact_written[i]) begin
        read_word(core_ctrl_pkg::INTERACT_BASE + 32'(i * 4));
      end
    end
    foreach (UNMAPPED_ADDR[i]) begin
      write_word(UNMAPPED_ADDR[i], $urandom());
      read_word(UNMAPPED_ADDR[i]);
    end

    // slot updates and the active slot lookup
    for (int i = 0; i < 20; i++) begin
      send_slot_update(16'($urandom()), $urandom());
    end
    for (int i = 0; i < 64; i++) begin
      read_word(core_ctrl_pkg::SLOT_BASE + 32'(i * 4));
    end
    for (int i = 0; i < 8; i++) begin
      id = 16'($urandom());
      active_slot_id = id;
      next_cycle();
      next_cycle();
      check_value("active_slot_size", active_slot_size, slot_model[id[5:0]]);
    end

    // both masters at once
    fork
      begin
        for (int i = 0; i < 16; i++) begin
          c_addr = core_ctrl_pkg::INTERACT_BASE + 32'($urandom_range(63, 0) * 4);
          write_word(c_addr, $urandom());
          read_word(c_addr);
        end
      end
      begin
        for (int k = 0; k < 16; k++) begin
          send_slot_update(16'($urandom()), $urandom());
        end
      end
    join
    check_value("bridge_busy", bridge_busy, 0);
    check_value("slot_update_ready", slot_update_ready, 1);
    for (int i = 0; i < 64; i++) begin
      read_word(core_ctrl_pkg::SLOT_BASE + 32'(i * 4));
    end

    // menu reset hold
    write_word(core_ctrl_pkg::CTRL_BASE + core_ctrl_pkg::REG_MENU_RESET, 32'h1);
    measure_reset_pulse(len);
    check_value("core_reset cycles", len, core_ctrl_pkg::RESET_HOLD_CYCLES);

    // button is ignored until enabled
    reset_button = 1'b1;
    repeat (4) begin
      next_cycle();
      check_value("core_reset", core_reset, 0);
    end
    reset_button = 1'b0;
    next_cycle();
    write_word(core_ctrl_pkg::CTRL_BASE + core_ctrl_pkg::REG_RESET_PLUS, 32'h1);
    read_word(core_ctrl_pkg::CTRL_BASE + core_ctrl_pkg::REG_RESET_PLUS);
    reset_button = 1'b1;
    measure_reset_pulse(len);
    check_value("core_reset cycles", len, core_ctrl_pkg::RESET_HOLD_CYCLES);
    reset_button = 1'b0;

    // seconds counter
    lval = $urandom() & 32'h0fff_ffff;
    write_word(core_ctrl_pkg::CTRL_BASE + core_ctrl_pkg::REG_RTC_SECONDS, lval);
    // counter and divider restart at the edge that completes the write
    t_load = $time;
    check_value("rtc_seconds", rtc_seconds, lval);
    read_word(core_ctrl_pkg::CTRL_BASE + core_ctrl_pkg::REG_RTC_SECONDS);
    repeat (200) next_cycle();
    elapsed = int'(($time - t_load) / CLK_PERIOD);
    check_value("rtc_seconds", rtc_seconds, lval + 32'(elapsed / RTC_TICKS));

    next_cycle();
    if (expected_q.size() != 0) begin
      abort_run("bridge reads finished without returning data");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+test
logic/core_ctrl_pkg.sv
logic/wb_if.sv
logic/wb_shared_bus.sv
logic/bridge_wb_master.sv
logic/slot_size_writer.sv
logic/ctrl_regs.sv
logic/interact_regs.sv
logic/slot_table.sv
logic/core_ctrl_top.sv
test/tb_core_ctrl.sv

/* Bender.yml */
package:
  name: core_ctrl

sources:
  - logic/core_ctrl_pkg.sv
  - logic/wb_if.sv
  - logic/wb_shared_bus.sv
  - logic/bridge_wb_master.sv
  - logic/slot_size_writer.sv
  - logic/ctrl_regs.sv
  - logic/interact_regs.sv
  - logic/slot_table.sv
  - logic/core_ctrl_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_core_ctrl.sv
